// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////

  // Data and address width
  localparam int XLEN       = 32;
  // Register index width
  localparam int REG_AW     = 5;
  // Data memory words and index width
  localparam int DMEM_DEPTH = 256;
  localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
  // PC after reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  //////////////////////////////
  // Opcodes and function codes
  //////////////////////////////

  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_ADDIU = 6'b001001;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_BNE   = 6'b000101;
  // Load group 100xxx, store group 101xxx
  localparam logic [2:0] OP_LOAD_GRP  = 3'b100;
  localparam logic [2:0] OP_STORE_GRP = 3'b101;

  // R-type funct field
  localparam logic [5:0] FN_ADD  = 6'h20;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUB  = 6'h22;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  //////////////////////////////
  // Types
  //////////////////////////////

  // ALU class chosen by the main decoder
  typedef enum logic [2:0] {
    ALU_ADD       = 3'd0,
    ALU_SUB_EQ    = 3'd1,
    ALU_SUB_NE    = 3'd2,
    ALU_FUNCT     = 3'd3,
    ALU_LOGIC_IMM = 3'd4
  } alu_class_e;

  // Main control word
  typedef struct packed {
    logic       reg_dst;
    logic       reg_write;
    logic       alu_src;
    logic       zero_ext;
    logic       branch;
    logic       mem_read;
    logic       mem_write;
    logic       mem_to_reg;
    alu_class_e alu_class;
  } ctrl_t;

  // R-type view of an instruction
  typedef struct packed {
    logic [5:0]        opcode;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic [4:0]        shamt;
    logic [5:0]        funct;
  } r_fields_t;

  // I-type view of an instruction
  typedef struct packed {
    logic [5:0]        opcode;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [15:0]       imm16;
  } i_fields_t;

  // Same instruction word, two decodings
  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_u;

  // Retire record, one per instruction
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   next_pc;
    logic              rf_we;
    logic [REG_AW-1:0] rf_addr;
    logic [XLEN-1:0]   rf_data;
    logic              mem_we;
  } retire_t;

  // Step sequencer states
  typedef enum logic [1:0] {
    S_FETCH = 2'd0,
    S_EXEC  = 2'd1,
    S_MEM   = 2'd2,
    S_WB    = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

// File: verilog/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
  input  wire logic [5:0]      i_opcode,
  output mips_pkg::ctrl_t      o_ctrl
);

  always_comb begin
    // Everything inactive unless the opcode picks a class
    o_ctrl = '0;
    o_ctrl.alu_class = mips_pkg::ALU_ADD;

    case (i_opcode)
      //////////////////////////////
      // Register-register
      //////////////////////////////
      mips_pkg::OP_RTYPE: begin
        // Destination is rd, funct picks the operation
        o_ctrl.reg_dst   = 1'b1;
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_class = mips_pkg::ALU_FUNCT;
      end

      //////////////////////////////
      // Immediates
      //////////////////////////////
      mips_pkg::OP_ADDI,
      mips_pkg::OP_ADDIU: begin
        // Sign-extended immediate into rt
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.alu_class = mips_pkg::ALU_ADD;
      end
      mips_pkg::OP_ANDI,
      mips_pkg::OP_ORI,
      mips_pkg::OP_XORI: begin
        // Logical ops take a zero-extended immediate
        o_ctrl.reg_write = 1'b1;
        o_ctrl.alu_src   = 1'b1;
        o_ctrl.zero_ext  = 1'b1;
        o_ctrl.alu_class = mips_pkg::ALU_LOGIC_IMM;
      end

      //////////////////////////////
      // Branches
      //////////////////////////////
      mips_pkg::OP_BEQ: begin
        // Taken when rs - rt is zero
        o_ctrl.branch    = 1'b1;
        o_ctrl.alu_class = mips_pkg::ALU_SUB_EQ;
      end
      mips_pkg::OP_BNE: begin
        // Taken when rs - rt is nonzero
        o_ctrl.branch    = 1'b1;
        o_ctrl.alu_class = mips_pkg::ALU_SUB_NE;
      end

      default: begin
        // Load and store groups match on the top three bits
        if (i_opcode[5:3] == mips_pkg::OP_LOAD_GRP) begin
          o_ctrl.reg_write  = 1'b1;
          o_ctrl.alu_src    = 1'b1;
          o_ctrl.mem_read   = 1'b1;
          o_ctrl.mem_to_reg = 1'b1;
          o_ctrl.alu_class  = mips_pkg::ALU_ADD;
        end else if (i_opcode[5:3] == mips_pkg::OP_STORE_GRP) begin
          // Address is rs + offset, data comes from rt
          o_ctrl.alu_src    = 1'b1;
          o_ctrl.mem_write  = 1'b1;
          o_ctrl.alu_class  = mips_pkg::ALU_ADD;
        end
        // Anything else retires as a no-op
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
  input  mips_pkg::instr_u                i_instr,
  input  mips_pkg::alu_class_e            i_alu_class,
  input  wire logic [mips_pkg::XLEN-1:0]  i_op_a,
  input  wire logic [mips_pkg::XLEN-1:0]  i_op_b,
  output logic      [mips_pkg::XLEN-1:0]  o_result,
  output logic                            o_take_branch
);

  logic [mips_pkg::XLEN-1:0] sum;
  logic [mips_pkg::XLEN-1:0] diff;
  logic                      less;

  // Shared arithmetic
  assign sum  = i_op_a + i_op_b;
  assign diff = i_op_a - i_op_b;
  // Signed compare for slt
  assign less = $signed(i_op_a) < $signed(i_op_b);

  always_comb begin
    o_result      = sum;
    o_take_branch = 1'b0;

    case (i_alu_class)
      mips_pkg::ALU_ADD: o_result = sum;

      // Branch compare through subtraction
      mips_pkg::ALU_SUB_EQ: begin
        o_result      = diff;
        o_take_branch = (diff == '0);
      end
      mips_pkg::ALU_SUB_NE: begin
        o_result      = diff;
        o_take_branch = (diff != '0);
      end

      // R-type, operation from funct
      mips_pkg::ALU_FUNCT: begin
        case (i_instr.r_fields.funct)
          mips_pkg::FN_ADD,
          mips_pkg::FN_ADDU: o_result = sum;
          mips_pkg::FN_SUB:  o_result = diff;
          mips_pkg::FN_AND:  o_result = i_op_a & i_op_b;
          mips_pkg::FN_OR:   o_result = i_op_a | i_op_b;
          mips_pkg::FN_XOR:  o_result = i_op_a ^ i_op_b;
          mips_pkg::FN_SLT:  o_result = {{(mips_pkg::XLEN-1){1'b0}}, less};
          default:           o_result = '0;
        endcase
      end

      // andi 00, ori 01, xori 10 in the low opcode bits
      mips_pkg::ALU_LOGIC_IMM: begin
        case (i_instr.i_fields.opcode[1:0])
          2'b00:   o_result = i_op_a & i_op_b;
          2'b01:   o_result = i_op_a | i_op_b;
          2'b10:   o_result = i_op_a ^ i_op_b;
          default: o_result = '0;
        endcase
      end

      default: o_result = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                          i_clk,
  input  wire logic                          i_arst_n,
  input  wire logic [mips_pkg::REG_AW-1:0]   i_rs_addr,
  input  wire logic [mips_pkg::REG_AW-1:0]   i_rt_addr,
  input  wire logic                          i_we,
  input  wire logic [mips_pkg::REG_AW-1:0]   i_wr_addr,
  input  wire logic [mips_pkg::XLEN-1:0]     i_wr_data,
  output logic      [mips_pkg::XLEN-1:0]     o_rs_data,
  output logic      [mips_pkg::XLEN-1:0]     o_rt_data
);

  logic [mips_pkg::XLEN-1:0] regs [2**mips_pkg::REG_AW];

  // Single write port, register zero never written
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 2**mips_pkg::REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  // Combinational reads
  // Register zero forced to 0
  assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
  assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  wire logic                        i_clk,
  input  wire logic                        i_en,
  input  wire logic                        i_we,
  input  wire logic [mips_pkg::XLEN-1:0]   i_addr,
  input  wire logic [mips_pkg::XLEN-1:0]   i_wr_data,
  output logic      [mips_pkg::XLEN-1:0]   o_rd_data
);

  logic [mips_pkg::XLEN-1:0]    mem [mips_pkg::DMEM_DEPTH];
  logic [mips_pkg::DMEM_AW-1:0] idx;

  // Word index, byte offset dropped
  assign idx = i_addr[mips_pkg::DMEM_AW+1:2];

  // Memory starts cleared
  initial begin
    for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Registered read, write when enabled with i_we
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[idx] <= i_wr_data;
      end
      o_rd_data <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
  input  wire logic             i_clk,
  input  wire logic             i_arst_n,
  input  wire logic             i_instr_valid,
  input  mips_pkg::ctrl_t       i_ctrl,
  output logic                  o_instr_ready,
  output logic                  o_en_exec,
  output logic                  o_en_mem,
  output logic                  o_en_wb
);

  mips_pkg::seq_state_e state_q;
  mips_pkg::seq_state_e state_d;

  //////////////////////////////
  // Next step
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Wait here until an instruction arrives
      mips_pkg::S_FETCH: begin
        if (i_instr_valid) begin
          state_d = mips_pkg::S_EXEC;
        end
      end
      // Memory step only for loads and stores
      mips_pkg::S_EXEC: begin
        if (i_ctrl.mem_read || i_ctrl.mem_write) begin
          state_d = mips_pkg::S_MEM;
        end else begin
          state_d = mips_pkg::S_WB;
        end
      end
      mips_pkg::S_MEM: state_d = mips_pkg::S_WB;
      mips_pkg::S_WB:  state_d = mips_pkg::S_FETCH;
      default:         state_d = mips_pkg::S_FETCH;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= mips_pkg::S_FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  // Step enables straight from the state
  assign o_instr_ready = (state_q == mips_pkg::S_FETCH);
  assign o_en_exec     = (state_q == mips_pkg::S_EXEC);
  assign o_en_mem      = (state_q == mips_pkg::S_MEM);
  assign o_en_wb       = (state_q == mips_pkg::S_WB);

endmodule

`default_nettype wire

// File: verilog/pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
  input  wire logic                        i_clk,
  input  wire logic                        i_arst_n,
  input  wire logic                        i_en,
  input  wire logic                        i_take_branch,
  input  wire logic [15:0]                 i_imm16,
  output logic      [mips_pkg::XLEN-1:0]   o_pc,
  output logic      [mips_pkg::XLEN-1:0]   o_next_pc
);

  logic [mips_pkg::XLEN-1:0] seq_pc;
  logic [mips_pkg::XLEN-1:0] br_off;

  // Sequential address
  assign seq_pc = o_pc + 32'd4;
  // Word offset, sign-extended and shifted by two
  assign br_off = {{(mips_pkg::XLEN-18){i_imm16[15]}}, i_imm16, 2'b00};
  // Branch target relative to pc + 4
  assign o_next_pc = i_take_branch ? (seq_pc + br_off) : seq_pc;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pc <= mips_pkg::RESET_PC;
    end else if (i_en) begin
      o_pc <= o_next_pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
  input  wire logic                        i_clk,
  input  wire logic                        i_arst_n,
  input  wire logic                        i_instr_valid,
  output logic                             o_instr_ready,
  input  wire logic [mips_pkg::XLEN-1:0]   i_instr,
  output logic                             o_retire_valid,
  output mips_pkg::retire_t                o_retire
);

  mips_pkg::instr_u              instr_q;
  mips_pkg::ctrl_t               ctrl;
  logic                          en_exec;
  logic                          en_mem;
  logic                          en_wb;
  logic [mips_pkg::XLEN-1:0]     rs_data;
  logic [mips_pkg::XLEN-1:0]     rt_data;
  logic [mips_pkg::XLEN-1:0]     imm_ext;
  logic [mips_pkg::XLEN-1:0]     op_b;
  logic [mips_pkg::XLEN-1:0]     alu_result;
  logic                          alu_take;
  logic [mips_pkg::XLEN-1:0]     alu_q;
  logic [mips_pkg::XLEN-1:0]     store_q;
  logic                          take_q;
  logic [mips_pkg::XLEN-1:0]     mem_rd;
  logic [mips_pkg::REG_AW-1:0]   wr_addr;
  logic [mips_pkg::XLEN-1:0]     wr_data;
  logic [mips_pkg::XLEN-1:0]     pc;
  logic [mips_pkg::XLEN-1:0]     next_pc;

  //////////////////////////////
  // Instruction register
  //////////////////////////////
  // Loaded on the valid/ready transfer
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      instr_q <= '0;
    end else if (i_instr_valid && o_instr_ready) begin
      instr_q <= i_instr;
    end
  end

  main_decoder u_dec (
    .i_opcode (instr_q.r_fields.opcode),
    .o_ctrl   (ctrl)
  );

  step_sequencer u_seq (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_instr_valid (i_instr_valid),
    .i_ctrl        (ctrl),
    .o_instr_ready (o_instr_ready),
    .o_en_exec     (en_exec),
    .o_en_mem      (en_mem),
    .o_en_wb       (en_wb)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  reg_file u_rf (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs_addr (instr_q.r_fields.rs),
    .i_rt_addr (instr_q.r_fields.rt),
    .i_we      (en_wb && ctrl.reg_write),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  // Zero or sign extension of imm16
  assign imm_ext = ctrl.zero_ext ?
                   {16'b0, instr_q.i_fields.imm16} :
                   {{16{instr_q.i_fields.imm16[15]}}, instr_q.i_fields.imm16};
  // Second operand, immediate or rt
  assign op_b = ctrl.alu_src ? imm_ext : rt_data;

  alu_unit u_alu (
    .i_instr       (instr_q),
    .i_alu_class   (ctrl.alu_class),
    .i_op_a        (rs_data),
    .i_op_b        (op_b),
    .o_result      (alu_result),
    .o_take_branch (alu_take)
  );

  // Result, store data and branch decision held after EXEC
  always_ff @(posedge i_clk) begin
    if (en_exec) begin
      alu_q   <= alu_result;
      store_q <= rt_data;
      take_q  <= ctrl.branch && alu_take;
    end
  end

  //////////////////////////////
  // Memory and writeback
  //////////////////////////////
  data_mem u_dmem (
    .i_clk     (i_clk),
    .i_en      (en_mem),
    .i_we      (ctrl.mem_write),
    .i_addr    (alu_q),
    .i_wr_data (store_q),
    .o_rd_data (mem_rd)
  );

  // rd for R-type, rt otherwise
  assign wr_addr = ctrl.reg_dst ? instr_q.r_fields.rd : instr_q.r_fields.rt;
  assign wr_data = ctrl.mem_to_reg ? mem_rd : alu_q;

  // PC moves on the edge that ends WB
  pc_counter u_pc (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_en          (en_wb),
    .i_take_branch (take_q),
    .i_imm16       (instr_q.i_fields.imm16),
    .o_pc          (pc),
    .o_next_pc     (next_pc)
  );

  // Retire record, valid for the WB cycle only
  assign o_retire_valid   = en_wb;
  assign o_retire.pc      = pc;
  assign o_retire.next_pc = next_pc;
  assign o_retire.rf_we   = ctrl.reg_write;
  assign o_retire.rf_addr = wr_addr;
  assign o_retire.rf_data = wr_data;
  assign o_retire.mem_we  = ctrl.mem_write;

endmodule

`default_nettype wire

// File: tb/mips_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_props (
  input wire logic            i_clk,
  input wire logic            i_arst_n,
  input wire logic            i_instr_valid,
  input wire logic            i_instr_ready,
  input wire logic            i_retire_valid,
  input mips_pkg::ctrl_t      i_ctrl,
  input mips_pkg::seq_state_e i_state
);

  logic in_flight;

  // Set on accept, cleared on retire
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_flight <= 1'b0;
    end else if (i_instr_valid && i_instr_ready) begin
      in_flight <= 1'b1;
    end else if (i_retire_valid) begin
      in_flight <= 1'b0;
    end
  end

  //////////////////////////////
  // Retire
  //////////////////////////////
  // Retire only for an accepted instruction
  a_retire_accepted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_retire_valid |-> in_flight)
    else $error("retire seen with no accepted instruction");

  // One cycle pulse per instruction
  a_retire_pulse: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_retire_valid |=> !i_retire_valid)
    else $error("retire valid held for more than one cycle");

  // Ready and retire never overlap
  a_ready_retire: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_instr_ready && i_retire_valid))
    else $error("ready and retire valid high in the same cycle");

  //////////////////////////////
  // Memory step
  //////////////////////////////
  // Loads and stores go EXEC then MEM
  a_mem_step: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_state == mips_pkg::S_EXEC && (i_ctrl.mem_read || i_ctrl.mem_write))
    |=> (i_state == mips_pkg::S_MEM))
    else $error("memory instruction skipped the memory step");

endmodule

bind mips_core mips_core_props u_props (
  .i_clk          (i_clk),
  .i_arst_n       (i_arst_n),
  .i_instr_valid  (i_instr_valid),
  .i_instr_ready  (o_instr_ready),
  .i_retire_valid (o_retire_valid),
  .i_ctrl         (ctrl),
  .i_state        (u_seq.state_q)
);

`default_nettype wire

// File: tb/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

  //////////////////////////////
  // Constants
  //////////////////////////////
  localparam int CLK_HALF = 4;
  // Word load and store opcodes
  localparam logic [5:0] OP_LW = 6'h23;
  localparam logic [5:0] OP_SW = 6'h2b;
  // Longest wait for ready or retire
  localparam int WAIT_LIMIT = 8;
  // About 90 instructions at up to 5 cycles plus idle gaps and margin
  localparam int INSTR_BUDGET   = 130;
  localparam int GAP_BUDGET     = 60;
  localparam int TIMEOUT_CYCLES = 4 + INSTR_BUDGET * 5 + GAP_BUDGET;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              instr_valid;
  logic              instr_ready;
  logic [31:0]       instr;
  logic              retire_valid;
  mips_pkg::retire_t retire;

  // Reference state
  logic [31:0] model_rf [32];
  logic [31:0] model_mem [mips_pkg::DMEM_DEPTH];
  logic [31:0] model_pc;

  string cur_test;
  int    error_count = 0;
  int    cycle_count = 0;

  mips_core dut (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .i_instr_valid  (instr_valid),
    .o_instr_ready  (instr_ready),
    .i_instr        (instr),
    .o_retire_valid (retire_valid),
    .o_retire       (retire)
  );

  always #CLK_HALF clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_failure();
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic report_failure();
    error_count++;
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_field(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Error: test %s, %s expected %h actual %h", cur_test, what, exp, act);
      report_failure();
    end
  endtask

  function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
    return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Reference model applied one instruction at a time
  task automatic predict(input logic [31:0] word, output mips_pkg::retire_t exp);
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] addr;
    op   = word[31:26];
    rs   = word[25:21];
    rt   = word[20:16];
    a    = model_rf[rs];
    b    = model_rf[rt];
    sext = {{16{word[15]}}, word[15:0]};
    zext = {16'h0000, word[15:0]};
    addr = a + sext;
    exp         = '0;
    exp.pc      = model_pc;
    exp.next_pc = model_pc + 32'd4;
    exp.rf_addr = rt;
    if (op == mips_pkg::OP_RTYPE) begin
      exp.rf_we   = 1'b1;
      exp.rf_addr = word[15:11];
      case (word[5:0])
        mips_pkg::FN_ADD,
        mips_pkg::FN_ADDU: exp.rf_data = a + b;
        mips_pkg::FN_SUB:  exp.rf_data = a - b;
        mips_pkg::FN_AND:  exp.rf_data = a & b;
        mips_pkg::FN_OR:   exp.rf_data = a | b;
        mips_pkg::FN_XOR:  exp.rf_data = a ^ b;
        mips_pkg::FN_SLT:  exp.rf_data = {31'd0, ($signed(a) < $signed(b))};
        default:           exp.rf_data = '0;
      endcase
    end else if (op == mips_pkg::OP_ADDI || op == mips_pkg::OP_ADDIU) begin
      exp.rf_we   = 1'b1;
      exp.rf_data = a + sext;
    end else if (op == mips_pkg::OP_ANDI) begin
      exp.rf_we   = 1'b1;
      exp.rf_data = a & zext;
    end else if (op == mips_pkg::OP_ORI) begin
      exp.rf_we   = 1'b1;
      exp.rf_data = a | zext;
    end else if (op == mips_pkg::OP_XORI) begin
      exp.rf_we   = 1'b1;
      exp.rf_data = a ^ zext;
    end else if (op[5:3] == 3'b100) begin
      // Word index from address bits 9 to 2
      exp.rf_we   = 1'b1;
      exp.rf_data = model_mem[addr[9:2]];
    end else if (op[5:3] == 3'b101) begin
      exp.mem_we             = 1'b1;
      model_mem[addr[9:2]]   = b;
    end else if (op == mips_pkg::OP_BEQ && a == b) begin
      exp.next_pc = model_pc + 32'd4 + {sext[29:0], 2'b00};
    end else if (op == mips_pkg::OP_BNE && a != b) begin
      exp.next_pc = model_pc + 32'd4 + {sext[29:0], 2'b00};
    end
    // Register zero never changes
    if (exp.rf_we && exp.rf_addr != 5'd0) begin
      model_rf[exp.rf_addr] = exp.rf_data;
    end
    model_pc = exp.next_pc;
  endtask

  // One valid/ready transfer and then the wait for the retire record
  task automatic issue(input logic [31:0] word, output mips_pkg::retire_t got,
                       output int lat);
    int waited;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= word;
    waited = 0;
    @(negedge clk);
    while (!instr_ready) begin
      waited++;
      assert (waited < WAIT_LIMIT) else begin
        $display("Test %s: core never became ready for the next instruction", cur_test);
        report_failure();
      end
      @(negedge clk);
    end
    // Transfer edge
    @(posedge clk);
    instr_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!retire_valid && lat < WAIT_LIMIT);
    assert (retire_valid) else begin
      $display("Test %s: no retire record after instruction %h", cur_test, word);
      report_failure();
    end
    got = retire;
  endtask

  // Send and compare the retire record with the model
  task automatic exec_check(input logic [31:0] word, output mips_pkg::retire_t got);
    mips_pkg::retire_t exp;
    int                lat;
    int                exp_lat;
    // Loads and stores take the extra memory step
    exp_lat = (word[31:29] == 3'b100 || word[31:29] == 3'b101) ? 3 : 2;
    predict(word, exp);
    issue(word, got, lat);
    check_field("latency", exp_lat, lat);
    check_field("pc", exp.pc, got.pc);
    check_field("next_pc", exp.next_pc, got.next_pc);
    check_field("rf_we", {31'd0, exp.rf_we}, {31'd0, got.rf_we});
    check_field("mem_we", {31'd0, exp.mem_we}, {31'd0, got.mem_we});
    if (exp.rf_we) begin
      check_field("rf_addr", {27'd0, exp.rf_addr}, {27'd0, got.rf_addr});
      check_field("rf_data", exp.rf_data, got.rf_data);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic test_reset();
    mips_pkg::retire_t got;
    cur_test = "reset";
    @(negedge clk);
    check_field("ready", 32'd1, {31'd0, instr_ready});
    check_field("retire_valid", 32'd0, {31'd0, retire_valid});
    exec_check(i_type(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005), got);
    // First instruction sits at the reset address
    check_field("first pc", 32'h0000_0000, got.pc);
    check_field("first next_pc", 32'h0000_0004, got.next_pc);
  endtask

  task automatic test_alu();
    mips_pkg::retire_t got;
    logic [15:0]       imm;
    logic [5:0]        imm_ops [5];
    logic [5:0]        fns [7];
    imm_ops = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_ANDI,
                mips_pkg::OP_ORI, mips_pkg::OP_XORI};
    fns     = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_AND,
                mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_SLT};
    cur_test = "alu";
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 5; j++) begin
        imm = 16'($urandom);
        // Odd passes use a negative immediate
        if (i[0]) begin
          imm[15] = 1'b1;
        end
        exec_check(i_type(imm_ops[j], 5'($urandom_range(31, 0)),
                          5'($urandom_range(31, 1)), imm), got);
      end
    end
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 7; j++) begin
        exec_check(r_type(5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                          5'($urandom_range(31, 1)), fns[j]), got);
      end
    end
    // Write to r0 is reported but has no effect
    cur_test = "alu_r0";
    exec_check(i_type(mips_pkg::OP_ADDI, 5'd1, 5'd0, 16'h0123), got);
    check_field("r0 rf_we", 32'd1, {31'd0, got.rf_we});
    exec_check(r_type(5'd0, 5'd0, 5'd3, mips_pkg::FN_OR), got);
    check_field("r0 read", 32'd0, got.rf_data);
  endtask

  task automatic test_memory();
    mips_pkg::retire_t got;
    logic [7:0]        widx;
    logic [15:0]       data;
    cur_test = "memory";
    for (int i = 0; i < 4; i++) begin
      widx = 8'($urandom);
      data = 16'($urandom);
      exec_check(i_type(mips_pkg::OP_ADDI, 5'd0, 5'd11, data), got);
      exec_check(i_type(OP_SW, 5'd0, 5'd11, {6'd0, widx, 2'b00}), got);
      check_field("sw mem_we", 32'd1, {31'd0, got.mem_we});
      exec_check(i_type(OP_LW, 5'd0, 5'd12, {6'd0, widx, 2'b00}), got);
      check_field("lw data", {{16{data[15]}}, data}, got.rf_data);
    end
    // Negative offset from a base register
    exec_check(i_type(mips_pkg::OP_ORI, 5'd0, 5'd10, 16'h0200), got);
    exec_check(i_type(OP_SW, 5'd10, 5'd11, 16'hfff8), got);
    exec_check(i_type(OP_LW, 5'd0, 5'd13, 16'h01f8), got);
  endtask

  task automatic test_branch();
    mips_pkg::retire_t got;
    logic [31:0]       prog [9];
    logic [31:0]       base;
    int                idx;
    int                steps;
    cur_test = "branch";
    prog[0] = i_type(mips_pkg::OP_ADDI, 5'd0, 5'd1, 16'd3);
    prog[1] = i_type(mips_pkg::OP_ADDI, 5'd0, 5'd2, 16'd0);
    // Loop body counts r2 up to r1
    prog[2] = i_type(mips_pkg::OP_ADDI, 5'd2, 5'd2, 16'd1);
    prog[3] = i_type(mips_pkg::OP_BNE, 5'd2, 5'd1, 16'hfffe);
    prog[4] = i_type(mips_pkg::OP_BEQ, 5'd1, 5'd0, 16'd3);
    prog[5] = i_type(mips_pkg::OP_BEQ, 5'd2, 5'd1, 16'd1);
    prog[6] = i_type(mips_pkg::OP_ADDI, 5'd0, 5'd7, 16'd99);
    prog[7] = i_type(mips_pkg::OP_BNE, 5'd1, 5'd1, 16'hfffa);
    prog[8] = i_type(mips_pkg::OP_ORI, 5'd0, 5'd8, 16'h0055);
    base  = model_pc;
    idx   = 0;
    steps = 0;
    while (idx != 9) begin
      exec_check(prog[idx], got);
      steps++;
      // Fetch follows the retired next_pc
      idx = int'((got.next_pc - base) >> 2);
      assert (idx <= 9 && steps < 20) else begin
        $display("Test branch: program flow left the code at pc %h", got.next_pc);
        report_failure();
      end
    end
    // Two setup steps plus three loop passes plus four more
    check_field("executed count", 32'd12, steps);
  endtask

  task automatic test_gaps();
    mips_pkg::retire_t got;
    int                gap;
    logic [31:0]       nop_pc;
    cur_test = "gaps";
    for (int i = 0; i < 6; i++) begin
      gap = $urandom_range(6, 1);
      repeat (gap) begin
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_field("gap retire_valid", 32'd0, {31'd0, retire_valid});
        check_field("gap ready", 32'd1, {31'd0, instr_ready});
      end
      exec_check(i_type(mips_pkg::OP_ADDIU, 5'($urandom_range(31, 0)),
                        5'($urandom_range(31, 1)), 16'($urandom)), got);
    end
    // Unknown opcodes including the multiply class
    cur_test = "unknown";
    nop_pc = model_pc;
    exec_check({6'b111111, 26'($urandom)}, got);
    check_field("nop next_pc", nop_pc + 32'd4, got.next_pc);
    nop_pc = model_pc;
    exec_check({6'b011100, 26'($urandom)}, got);
    check_field("nop rf_we", 32'd0, {31'd0, got.rf_we});
    check_field("nop mem_we", 32'd0, {31'd0, got.mem_we});
    check_field("nop next_pc", nop_pc + 32'd4, got.next_pc);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    void'($urandom(32'hddb0_d7ba));
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    for (int i = 0; i < mips_pkg::DMEM_DEPTH; i++) begin
      model_mem[i] = '0;
    end
    model_pc = mips_pkg::RESET_PC;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    test_alu();
    test_memory();
    test_branch();
    test_gaps();
    if (error_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      report_failure();
    end
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/mips_pkg.sv
verilog/main_decoder.sv
verilog/alu_unit.sv
verilog/reg_file.sv
verilog/data_mem.sv
verilog/step_sequencer.sv
verilog/pc_counter.sv
verilog/mips_core.sv
tb/mips_core_props.sv
tb/mips_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := mips_core_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
